//--- logic/classifier_pkg.sv
package classifier_pkg;

  // five-tuple layout, src_ip in the top bits
  localparam int TUPLE_BITS    = 104;
  localparam int SRC_IP_LSB    = 72;
  localparam int DST_IP_LSB    = 40;
  localparam int SRC_PORT_LSB  = 24;
  localparam int DST_PORT_LSB  = 8;
  localparam int PROTO_LSB     = 0;
  localparam int PROTO_BITS    = 8;

  localparam int RULE_ID_BITS  = 11;
  localparam int FIELD_BITS    = 16;
  localparam int GROUP_NUM     = 2;
  localparam int GROUP_BITS    = 1;

  // cfg_addr: {stage, group, node index} for node writes, segment index for segment writes
  localparam int CFG_ADDR_BITS  = 16;
  localparam int STAGE_SEL_BITS = 4;
  localparam int CFG_DATA_BITS  = 64;

  // node entry inside cfg_data, next index sits in the low bits
  localparam int FIELD_SEL_BITS = 3;
  localparam int NODE_VALID_BIT = 63;
  localparam int NODE_FIELD_LSB = 60;
  localparam int NODE_VALUE_LSB = 44;
  localparam int NODE_MASK_LSB  = 28;
  localparam int NODE_RULE_LSB  = 17;

  typedef enum logic [1:0] {
    CMD_NOP        = 2'd0,
    CMD_SEARCH     = 2'd1,
    CMD_WRITE_SEG  = 2'd2,
    CMD_WRITE_NODE = 2'd3
  } cmd_e;

  typedef enum logic [2:0] {
    FIELD_SRC_IP_HI = 3'd0,
    FIELD_SRC_IP_LO = 3'd1,
    FIELD_DST_IP_HI = 3'd2,
    FIELD_DST_IP_LO = 3'd3,
    FIELD_SRC_PORT  = 3'd4,
    FIELD_DST_PORT  = 3'd5,
    FIELD_PROTO     = 3'd6
  } field_e;

  // pick one 16-bit slice of the tuple, proto is zero-extended
  function automatic logic [FIELD_BITS-1:0] select_field(
    input logic [TUPLE_BITS-1:0] tuple,
    input field_e                sel
  );
    case (sel)
      FIELD_SRC_IP_HI: return tuple[SRC_IP_LSB+FIELD_BITS +: FIELD_BITS];
      FIELD_SRC_IP_LO: return tuple[SRC_IP_LSB +: FIELD_BITS];
      FIELD_DST_IP_HI: return tuple[DST_IP_LSB+FIELD_BITS +: FIELD_BITS];
      FIELD_DST_IP_LO: return tuple[DST_IP_LSB +: FIELD_BITS];
      FIELD_SRC_PORT:  return tuple[SRC_PORT_LSB +: FIELD_BITS];
      FIELD_DST_PORT:  return tuple[DST_PORT_LSB +: FIELD_BITS];
      FIELD_PROTO:     return {{(FIELD_BITS-PROTO_BITS){1'b0}}, tuple[PROTO_LSB +: PROTO_BITS]};
      default:         return '0;
    endcase
  endfunction

endpackage

//--- logic/segment_lookup.sv
`timescale 1ns/1ps

module segment_lookup
  import classifier_pkg::*;
#(
  parameter int SEG_ADDR_BITS  = 6,
  parameter int NODE_ADDR_BITS = 6
)
(
  input  logic                                     clk,
  input  logic                                     rst,
  input  cmd_e                                     command,
  input  logic [TUPLE_BITS-1:0]                    tuple,
  input  logic [CFG_ADDR_BITS-1:0]                 cfg_addr,
  input  logic [CFG_DATA_BITS-1:0]                 cfg_data,
  input  logic                                     valid_in,
  output logic                                     valid_out,
  output logic [TUPLE_BITS-1:0]                    tuple_out,
  output logic [GROUP_NUM-1:0][NODE_ADDR_BITS-1:0] start_index
);

  localparam int SEG_DEPTH  = 1 << SEG_ADDR_BITS;
  localparam int ENTRY_BITS = GROUP_NUM * NODE_ADDR_BITS;

  logic [ENTRY_BITS-1:0]    seg_mem [SEG_DEPTH];
  logic [SEG_DEPTH-1:0]     seg_valid;
  logic                     wr_seg;
  logic [SEG_ADDR_BITS-1:0] wr_idx;
  logic [FIELD_BITS-1:0]    dst_ip_hi;
  logic [SEG_ADDR_BITS-1:0] seg_idx;
  logic [ENTRY_BITS-1:0]    seg_entry;

  assign wr_seg = (command == CMD_WRITE_SEG);
  assign wr_idx = cfg_addr[SEG_ADDR_BITS-1:0];

  // direct index from the top bits of dst_ip
  assign dst_ip_hi = select_field(tuple, FIELD_DST_IP_HI);
  assign seg_idx   = dst_ip_hi[FIELD_BITS-1 -: SEG_ADDR_BITS];

  // unwritten entries start every group at node 0
  assign seg_entry = seg_valid[seg_idx] ? seg_mem[seg_idx] : '0;

  always_ff @(posedge clk)
  begin
    if (wr_seg)
      seg_mem[wr_idx] <= cfg_data[ENTRY_BITS-1:0];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      seg_valid <= '0;
    else if (wr_seg)
      seg_valid[wr_idx] <= 1'b1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      valid_out <= 1'b0;
    else
      valid_out <= valid_in;
  end

  // group 0 start index lands in the low bits
  always_ff @(posedge clk)
  begin
    tuple_out   <= tuple;
    start_index <= seg_entry;
  end

endmodule

//--- logic/search_stage.sv
`timescale 1ns/1ps

module search_stage
  import classifier_pkg::*;
#(
  parameter int STAGE_ID       = 0,
  parameter int NODE_ADDR_BITS = 6
)
(
  input  logic                                     clk,
  input  logic                                     rst,
  input  cmd_e                                     command,
  input  logic [CFG_ADDR_BITS-1:0]                 cfg_addr,
  input  logic [CFG_DATA_BITS-1:0]                 cfg_data,
  input  logic                                     valid_in,
  input  logic [TUPLE_BITS-1:0]                    tuple_in,
  input  logic [GROUP_NUM-1:0][NODE_ADDR_BITS-1:0] index_in,
  input  logic [GROUP_NUM-1:0]                     match_in,
  input  logic [GROUP_NUM-1:0][RULE_ID_BITS-1:0]   best_rule_in,
  output logic                                     valid_out,
  output logic [TUPLE_BITS-1:0]                    tuple_out,
  output logic [GROUP_NUM-1:0][NODE_ADDR_BITS-1:0] index_out,
  output logic [GROUP_NUM-1:0]                     match_out,
  output logic [GROUP_NUM-1:0][RULE_ID_BITS-1:0]   best_rule_out
);

  localparam int NODE_DEPTH = 1 << NODE_ADDR_BITS;
  // the valid bit lives in its own array
  localparam int WORD_BITS  = CFG_DATA_BITS - 1;

  logic [WORD_BITS-1:0]                     node_mem [GROUP_NUM][NODE_DEPTH];
  logic [GROUP_NUM-1:0][NODE_DEPTH-1:0]     node_valid;
  logic                                     wr_node;
  logic [GROUP_BITS-1:0]                    wr_group;
  logic [NODE_ADDR_BITS-1:0]                wr_index;
  logic [STAGE_SEL_BITS-1:0]                wr_stage;
  logic [GROUP_NUM-1:0]                     hit;
  logic [GROUP_NUM-1:0][NODE_ADDR_BITS-1:0] next_index;
  logic [GROUP_NUM-1:0][RULE_ID_BITS-1:0]   next_best;

  // node write address is {stage, group, node index}
  assign wr_index = cfg_addr[NODE_ADDR_BITS-1:0];
  assign wr_group = cfg_addr[NODE_ADDR_BITS +: GROUP_BITS];
  assign wr_stage = cfg_addr[NODE_ADDR_BITS+GROUP_BITS +: STAGE_SEL_BITS];
  assign wr_node  = (command == CMD_WRITE_NODE) && (wr_stage == STAGE_SEL_BITS'(STAGE_ID));

  always_ff @(posedge clk)
  begin
    if (wr_node)
      node_mem[wr_group][wr_index] <= cfg_data[WORD_BITS-1:0];
  end

  // a write with the valid bit low removes the node
  always_ff @(posedge clk)
  begin
    if (rst)
      node_valid <= '0;
    else if (wr_node)
      node_valid[wr_group][wr_index] <= cfg_data[NODE_VALID_BIT];
  end

  for (genvar g = 0; g < GROUP_NUM; g++)
  begin : g_group
    logic [WORD_BITS-1:0]    word;
    logic                    node_ok;
    logic [FIELD_BITS-1:0]   field;
    logic [FIELD_BITS-1:0]   value;
    logic [FIELD_BITS-1:0]   mask;
    logic [RULE_ID_BITS-1:0] rule;

    assign word    = node_mem[g][index_in[g]];
    assign node_ok = node_valid[g][index_in[g]];
    assign field   = select_field(tuple_in, field_e'(word[NODE_FIELD_LSB +: FIELD_SEL_BITS]));
    assign value   = word[NODE_VALUE_LSB +: FIELD_BITS];
    assign mask    = word[NODE_MASK_LSB +: FIELD_BITS];
    assign rule    = word[NODE_RULE_LSB +: RULE_ID_BITS];

    // masked-out bits never block a hit
    assign hit[g] = node_ok && (((field ^ value) & mask) == '0);

    // an invalid node ends the chain at index 0
    assign next_index[g] = node_ok ? word[NODE_ADDR_BITS-1:0] : '0;

    // keep the larger rule ID, ignoring a stale best when nothing matched yet
    assign next_best[g] = (hit[g] && (!match_in[g] || (rule > best_rule_in[g]))) ?
                          rule : best_rule_in[g];
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      valid_out <= 1'b0;
    else
      valid_out <= valid_in;
  end

  always_ff @(posedge clk)
  begin
    tuple_out     <= tuple_in;
    index_out     <= next_index;
    match_out     <= match_in | hit;
    best_rule_out <= next_best;
  end

endmodule

//--- logic/rule_resolve.sv
`timescale 1ns/1ps

module rule_resolve
  import classifier_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  logic                                   valid_in,
  input  logic [GROUP_NUM-1:0]                   match_in,
  input  logic [GROUP_NUM-1:0][RULE_ID_BITS-1:0] best_rule_in,
  output logic                                   result_valid,
  output logic                                   match,
  output logic [RULE_ID_BITS-1:0]                match_rule_id
);

  logic                    any_match;
  logic [RULE_ID_BITS-1:0] top_rule;

  // highest rule among the groups that matched, ties simply give the same ID
  always_comb
  begin
    any_match = 1'b0;
    top_rule  = '0;
    for (int g = 0; g < GROUP_NUM; g++)
    begin
      if (match_in[g])
      begin
        any_match = 1'b1;
        if (best_rule_in[g] > top_rule)
          top_rule = best_rule_in[g];
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      result_valid <= 1'b0;
      match        <= 1'b0;
    end
    else
    begin
      result_valid <= valid_in;
      // match only rides on a real result
      match        <= valid_in && any_match;
    end
  end

  // stays 0 when no group matches
  always_ff @(posedge clk)
  begin
    match_rule_id <= top_rule;
  end

endmodule

//--- logic/packet_classifier.sv
`timescale 1ns/1ps

module packet_classifier
  import classifier_pkg::*;
#(
  parameter int STAGE_NUM      = 4,
  parameter int SEG_ADDR_BITS  = 6,
  parameter int NODE_ADDR_BITS = 6
)
(
  input  logic                       clk,
  input  logic                       rst,
  input  cmd_e                       command,
  input  logic [TUPLE_BITS-1:0]      tuple,
  input  logic [CFG_ADDR_BITS-1:0]   cfg_addr,
  input  logic [CFG_DATA_BITS-1:0]   cfg_data,
  output logic                       result_valid,
  output logic                       match,
  output logic [RULE_ID_BITS-1:0]    match_rule_id
);

  cmd_e                       cmd_q;
  logic [TUPLE_BITS-1:0]      tuple_q;
  logic [CFG_ADDR_BITS-1:0]   cfg_addr_q;
  logic [CFG_DATA_BITS-1:0]   cfg_data_q;
  logic                       search_q;

  // entry s feeds stage s, entry STAGE_NUM is the chain output
  logic                                     chain_valid [STAGE_NUM+1];
  logic [TUPLE_BITS-1:0]                    chain_tuple [STAGE_NUM+1];
  logic [GROUP_NUM-1:0][NODE_ADDR_BITS-1:0] chain_index [STAGE_NUM+1];
  logic [GROUP_NUM-1:0]                     chain_match [STAGE_NUM+1];
  logic [GROUP_NUM-1:0][RULE_ID_BITS-1:0]   chain_best  [STAGE_NUM+1];

  // input capture, one cycle
  always_ff @(posedge clk)
  begin
    if (rst)
      cmd_q <= CMD_NOP;
    else
      cmd_q <= command;
  end

  always_ff @(posedge clk)
  begin
    tuple_q    <= tuple;
    cfg_addr_q <= cfg_addr;
    cfg_data_q <= cfg_data;
  end

  assign search_q = (cmd_q == CMD_SEARCH);

  segment_lookup #(
    .SEG_ADDR_BITS  (SEG_ADDR_BITS),
    .NODE_ADDR_BITS (NODE_ADDR_BITS)
  ) i_segment_lookup (
    .clk         (clk),
    .rst         (rst),
    .command     (cmd_q),
    .tuple       (tuple_q),
    .cfg_addr    (cfg_addr_q),
    .cfg_data    (cfg_data_q),
    .valid_in    (search_q),
    .valid_out   (chain_valid[0]),
    .tuple_out   (chain_tuple[0]),
    .start_index (chain_index[0])
  );

  // nothing has matched before the first stage
  assign chain_match[0] = '0;
  assign chain_best[0]  = '0;

  for (genvar s = 0; s < STAGE_NUM; s++)
  begin : g_stage
    search_stage #(
      .STAGE_ID       (s),
      .NODE_ADDR_BITS (NODE_ADDR_BITS)
    ) i_search_stage (
      .clk           (clk),
      .rst           (rst),
      .command       (cmd_q),
      .cfg_addr      (cfg_addr_q),
      .cfg_data      (cfg_data_q),
      .valid_in      (chain_valid[s]),
      .tuple_in      (chain_tuple[s]),
      .index_in      (chain_index[s]),
      .match_in      (chain_match[s]),
      .best_rule_in  (chain_best[s]),
      .valid_out     (chain_valid[s+1]),
      .tuple_out     (chain_tuple[s+1]),
      .index_out     (chain_index[s+1]),
      .match_out     (chain_match[s+1]),
      .best_rule_out (chain_best[s+1])
    );
  end

  rule_resolve i_rule_resolve (
    .clk           (clk),
    .rst           (rst),
    .valid_in      (chain_valid[STAGE_NUM]),
    .match_in      (chain_match[STAGE_NUM]),
    .best_rule_in  (chain_best[STAGE_NUM]),
    .result_valid  (result_valid),
    .match         (match),
    .match_rule_id (match_rule_id)
  );

endmodule

//--- sim/classifier_checker.sv
`timescale 1ns/1ps

module classifier_checker
  import classifier_pkg::*;
#(
  parameter int STAGE_NUM = 4
)
(
  input logic clk,
  input logic rst,
  input cmd_e command,
  input logic result_valid,
  input logic match
);

  // capture, segment read, the stages and resolve
  localparam int LATENCY = STAGE_NUM + 3;

  assert property (@(posedge clk) disable iff (rst)
    command == CMD_SEARCH |-> ##(LATENCY) result_valid)
    else $error("search not followed by result_valid after %0d cycles", LATENCY);

  assert property (@(posedge clk) disable iff (rst)
    result_valid |-> $past(command, LATENCY) == CMD_SEARCH)
    else $error("result_valid without a search %0d cycles earlier", LATENCY);

  assert property (@(posedge clk) disable iff (rst) match |-> result_valid)
    else $error("match high outside result_valid");

  assert property (@(posedge clk) rst |=> !result_valid)
    else $error("result_valid high during reset");

endmodule

bind packet_classifier classifier_checker #(
  .STAGE_NUM (STAGE_NUM)
) i_classifier_checker (
  .clk          (clk),
  .rst          (rst),
  .command      (command),
  .result_valid (result_valid),
  .match        (match)
);

//--- sim/classifier_tests.svh
// each driver takes one clock edge and a burst ends with go_idle
task automatic go_idle();
  @(posedge clk);
  command <= CMD_NOP;
endtask

task automatic write_segment(input int seg, input int start0, input int start1);
  @(posedge clk);
  command  <= CMD_WRITE_SEG;
  cfg_addr <= CFG_ADDR_BITS'(seg);
  cfg_data <= CFG_DATA_BITS'({NODE_ADDR_BITS'(start1), NODE_ADDR_BITS'(start0)});
  seg_model[seg] = {NODE_ADDR_BITS'(start1), NODE_ADDR_BITS'(start0)};
endtask

task automatic write_node(input int stage, input int group, input int idx,
                          input logic [CFG_DATA_BITS-1:0] data);
  @(posedge clk);
  command  <= CMD_WRITE_NODE;
  cfg_addr <= CFG_ADDR_BITS'({STAGE_SEL_BITS'(stage), GROUP_BITS'(group), NODE_ADDR_BITS'(idx)});
  cfg_data <= data;
  node_model[stage][group][idx] = data;
endtask

task automatic issue_search(input logic [TUPLE_BITS-1:0] t);
  @(posedge clk);
  command <= CMD_SEARCH;
  tuple   <= t;
  due_q.push_back(cycle_count + 1 + LATENCY);
  expect_q.push_back(expect_result(t));
endtask

task automatic wait_results();
  go_idle();
  while (due_q.size() > 0)
    @(negedge clk);
endtask

function automatic logic [CFG_DATA_BITS-1:0] make_node(input logic valid, input field_e field,
    input logic [15:0] value, input logic [15:0] mask, input logic [10:0] rule, input int next);
  logic [CFG_DATA_BITS-1:0] d;
  d = '0;
  d[63] = valid;
  d[62:60] = field;
  d[59:44] = value;
  d[43:28] = mask;
  d[27:17] = rule;
  d[NODE_ADDR_BITS-1:0] = NODE_ADDR_BITS'(next);
  return d;
endfunction

task automatic test_empty_tables();
  issue_search({32'h0A00_0001, 32'hC0A8_0101, 16'd1024, 16'd80, 8'd6});
  issue_search('1);
  wait_results();
endtask

task automatic test_single_node();
  write_node(0, 0, 0, make_node(1'b1, FIELD_DST_PORT, 16'h1F90, 16'hFFFF, 11'd42, 0));
  issue_search({32'h0A00_0001, 32'h0B00_0001, 16'd5000, 16'h1F90, 8'd17});
  // one masked bit off
  issue_search({32'h0A00_0001, 32'h0B00_0001, 16'd5000, 16'h1F98, 8'd17});
  wait_results();
endtask

task automatic test_node_chain();
  write_node(0, 0, 0, make_node(1'b1, FIELD_SRC_IP_HI, 16'h0A00, 16'hFF00, 11'd100, 5));
  write_node(1, 0, 5, make_node(1'b1, FIELD_PROTO, 16'h0006, 16'h00FF, 11'd300, 9));
  write_node(2, 0, 9, make_node(1'b1, FIELD_DST_PORT, 16'h0050, 16'hFFF0, 11'd200, 3));
  write_node(3, 0, 3, make_node(1'b1, FIELD_SRC_PORT, 16'h0000, 16'h0000, 11'd50, 0));
  issue_search({32'h0A01_0203, 32'h0C00_0001, 16'd3000, 16'h0055, 8'd6});
  // udp misses stage 1 only
  issue_search({32'h0A01_0203, 32'h0C00_0001, 16'd3000, 16'h0055, 8'd17});
  wait_results();
  // invalid middle node sends the rest of the chain to index 0
  write_node(1, 0, 5, make_node(1'b0, FIELD_PROTO, 16'h0006, 16'h00FF, 11'd300, 9));
  issue_search({32'h0A01_0203, 32'h0C00_0001, 16'd3000, 16'h0055, 8'd6});
  wait_results();
endtask

task automatic test_two_groups();
  // dst_ip 0xA8.. lands in segment 42
  write_segment(42, 10, 20);
  write_node(0, 0, 10, make_node(1'b1, FIELD_DST_IP_LO, 16'h0001, 16'hFFFF, 11'd500, 0));
  write_node(0, 1, 20, make_node(1'b1, FIELD_SRC_PORT, 16'd2000, 16'hFFFF, 11'd700, 11));
  write_node(1, 1, 11, make_node(1'b1, FIELD_PROTO, 16'h0011, 16'h00FF, 11'd900, 0));
  issue_search({32'h0101_0101, 32'hA8C0_0001, 16'd2000, 16'd53, 8'd6});
  issue_search({32'h0101_0101, 32'hA8C0_0001, 16'd2001, 16'd53, 8'd6});
  issue_search({32'h0101_0101, 32'hA8C0_0002, 16'd2000, 16'd53, 8'd6});
  wait_results();
endtask

task automatic test_random_stream();
  logic [TUPLE_BITS-1:0] t;
  logic [2:0]            f;
  logic                  v;
  logic [15:0]           value;
  logic [15:0]           mask;
  logic [10:0]           rule;
  int                    next;
  for (int i = 0; i < (1 << SEG_ADDR_BITS); i++)
    write_segment(i, int'(random_bits(3)), int'(random_bits(3)));
  for (int s = 0; s < STAGE_NUM; s++)
    for (int g = 0; g < GROUP_NUM; g++)
      for (int n = 0; n < 8; n++)
      begin
        v = (2'(random_bits(2)) != 2'd0);
        f = 3'(random_bits(3));
        if (f == 3'd7)
          f = 3'd6;
        value = 16'(random_bits(16));
        // sparse masks so that random tuples hit now and then
        mask = 16'(random_bits(16));
        mask = mask & 16'(random_bits(16));
        rule = 11'(random_bits(11));
        next = int'(random_bits(3));
        write_node(s, g, n, make_node(v, field_e'(f), value, mask, rule, next));
      end
  for (int i = 0; i < RANDOM_SEARCHES; i++)
  begin
    t[TUPLE_BITS-1 -: 40] = 40'(random_bits(40));
    t[63:0] = random_bits(64);
    issue_search(t);
  end
  wait_results();
endtask

task automatic test_node_rewrite();
  write_segment(63, 12, 12);
  write_node(0, 0, 12, make_node(1'b1, FIELD_DST_PORT, 16'd443, 16'hFFFF, 11'd3, 0));
  issue_search({32'h0202_0202, 32'hFC00_0000, 16'd4000, 16'd443, 8'd6});
  // the first search is still in flight when the node changes
  write_node(0, 0, 12, make_node(1'b1, FIELD_DST_PORT, 16'd443, 16'hFFFF, 11'd2047, 0));
  issue_search({32'h0202_0202, 32'hFC00_0000, 16'd4000, 16'd443, 8'd6});
  wait_results();
endtask

//--- sim/classifier_tb.sv
`timescale 1ns/1ps

module classifier_tb
  import classifier_pkg::*;
();

  localparam int STAGE_NUM       = 4;
  localparam int SEG_ADDR_BITS   = 6;
  localparam int NODE_ADDR_BITS  = 6;
  localparam int CLK_PERIOD      = 8;
  localparam int RESET_CYCLES    = 16;
  localparam int LATENCY         = STAGE_NUM + 3;
  localparam int RANDOM_SEARCHES = 200;
  // reset, random table fill, random stream and a drain after each directed burst
  localparam int TEST_CYCLES = RESET_CYCLES + 64 + 64 + RANDOM_SEARCHES + 16 * (LATENCY + 4);

  logic                     clk;
  logic                     rst;
  cmd_e                     command;
  logic [TUPLE_BITS-1:0]    tuple;
  logic [CFG_ADDR_BITS-1:0] cfg_addr;
  logic [CFG_DATA_BITS-1:0] cfg_data;
  logic                     result_valid;
  logic                     match;
  logic [RULE_ID_BITS-1:0]  match_rule_id;

  // model copies of both tables
  logic [GROUP_NUM*NODE_ADDR_BITS-1:0] seg_model [1 << SEG_ADDR_BITS];
  logic [CFG_DATA_BITS-1:0] node_model [STAGE_NUM][GROUP_NUM][1 << NODE_ADDR_BITS];

  // expected {match, rule} and due cycle, in issue order
  int                    due_q[$];
  logic [RULE_ID_BITS:0] expect_q[$];
  int                    cycle_count = 0;
  int                    check_count = 0;
  int                    error_count = 0;
  logic [15:0]           lfsr_state = 16'd16;

  packet_classifier #(
    .STAGE_NUM      (STAGE_NUM),
    .SEG_ADDR_BITS  (SEG_ADDR_BITS),
    .NODE_ADDR_BITS (NODE_ADDR_BITS)
  ) i_packet_classifier (
    .clk           (clk),
    .rst           (rst),
    .command       (command),
    .tuple         (tuple),
    .cfg_addr      (cfg_addr),
    .cfg_data      (cfg_data),
    .result_valid  (result_valid),
    .match         (match),
    .match_rule_id (match_rule_id)
  );

  initial
  begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk)
    cycle_count <= cycle_count + 1;

  // galois lfsr, one step per bit
  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out)
      lfsr_state = lfsr_state ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [63:0] random_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++)
      r = {r[62:0], lfsr_bit()};
    return r;
  endfunction

  // 16-bit slices of the five-tuple
  function automatic logic [15:0] pick_field(input logic [TUPLE_BITS-1:0] t,
                                             input logic [2:0] sel);
    case (sel)
      3'd0: return t[103:88];
      3'd1: return t[87:72];
      3'd2: return t[71:56];
      3'd3: return t[55:40];
      3'd4: return t[39:24];
      3'd5: return t[23:8];
      3'd6: return {8'h00, t[7:0]};
      default: return 16'h0000;
    endcase
  endfunction

  // walks both groups through all stages, returns {match, rule}
  function automatic logic [RULE_ID_BITS:0] expect_result(input logic [TUPLE_BITS-1:0] t);
    logic [GROUP_NUM*NODE_ADDR_BITS-1:0] entry;
    logic [NODE_ADDR_BITS-1:0]           idx;
    logic [CFG_DATA_BITS-1:0]            node;
    logic                                grp_hit;
    logic                                any_hit;
    logic [RULE_ID_BITS-1:0]             best;
    logic [RULE_ID_BITS-1:0]             top;
    entry = seg_model[t[71 -: SEG_ADDR_BITS]];
    any_hit = 1'b0;
    top = '0;
    for (int g = 0; g < GROUP_NUM; g++)
    begin
      idx = entry[g*NODE_ADDR_BITS +: NODE_ADDR_BITS];
      grp_hit = 1'b0;
      best = '0;
      for (int s = 0; s < STAGE_NUM; s++)
      begin
        node = node_model[s][g][idx];
        if (node[63] && (((pick_field(t, node[62:60]) ^ node[59:44]) & node[43:28]) == '0))
        begin
          if (!grp_hit || node[27:17] > best)
            best = node[27:17];
          grp_hit = 1'b1;
        end
        idx = node[63] ? node[NODE_ADDR_BITS-1:0] : '0;
      end
      if (grp_hit && best > top)
        top = best;
      any_hit = any_hit | grp_hit;
    end
    return {any_hit, top};
  endfunction

  `include "classifier_tests.svh"

  // result must land exactly LATENCY edges after the search was driven
  always @(negedge clk)
  begin
    if (!rst && due_q.size() > 0 && due_q[0] == cycle_count)
    begin
      check_count++;
      if (result_valid !== 1'b1)
      begin
        $display("result_valid missing at %0t for a search due in cycle %0d", $time, due_q[0]);
        error_count++;
      end
      else if ({match, match_rule_id} !== expect_q[0])
      begin
        $display("FAILED at %0t: expected match %0b rule %0d, got match %0b rule %0d", $time,
                 expect_q[0][RULE_ID_BITS], expect_q[0][RULE_ID_BITS-1:0], match, match_rule_id);
        error_count++;
      end
      void'(due_q.pop_front());
      void'(expect_q.pop_front());
    end
    else if (!rst && result_valid !== 1'b0)
    begin
      $display("result_valid pulsed at %0t with no search due", $time);
      error_count++;
    end
  end

  initial
  begin
    #(2 * TEST_CYCLES * CLK_PERIOD);
    $display("timeout: run still busy after %0d cycles", 2 * TEST_CYCLES);
    $display("SOME TESTS FAILED");
    $finish;
  end

  initial
  begin
    foreach (seg_model[i])
      seg_model[i] = '0;
    foreach (node_model[s, g, n])
      node_model[s][g][n] = '0;
    rst      = 1'b1;
    command  = CMD_NOP;
    tuple    = '0;
    cfg_addr = '0;
    cfg_data = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    test_empty_tables();
    test_single_node();
    test_node_chain();
    test_two_groups();
    test_random_stream();
    test_node_rewrite();
    $display("checks %0d, errors %0d", check_count, error_count);
    if (error_count == 0 && check_count > 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

//--- packet_classifier.f
+incdir+sim
logic/classifier_pkg.sv
logic/segment_lookup.sv
logic/search_stage.sv
logic/rule_resolve.sv
logic/packet_classifier.sv
sim/classifier_checker.sv
sim/classifier_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module classifier_tb \
		-f packet_classifier.f -o classifier_sim

run: compile
	./obj_dir/classifier_sim | tee sim.log
	grep -q "ALL TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
